//--- all.f
+incdir+dv
hw/fano_pkg.sv
hw/fano_ctrl.sv
hw/path_memory.sv
hw/branch_metric.sv
hw/path_metric_regs.sv
hw/fano_decoder_top.sv
dv/tb_fano_decoder.sv

//--- dv/fano_tb_model.svh
`ifndef FANO_TB_MODEL_SVH
`define FANO_TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference encoder and expected output queue
//////////////////////////////////////////////////////////////////////

// Encoder shift register, bit 0 holds the newest information bit
logic [CODE_LEN-1:0] enc_sr;
// Decided bits still to come out of the DUT
logic                exp_q[$];

// Systematic rate 1/2 branch for one information bit
function automatic branch_t encode_bit(input logic d);
    branch_t br;
    enc_sr = {enc_sr[CODE_LEN-2:0], d};
    br.d = d;
    // Parity over the taps of the extended history
    br.p = ^(enc_sr & PARITY_POLY);
    return br;
endfunction

// Channel error on one of the two bits
function automatic branch_t flip_one(input branch_t br, input logic on_data);
    branch_t res;
    res = br;
    if (on_data) begin
        res.d = ~res.d;
    end else begin
        res.p = ~res.p;
    end
    return res;
endfunction

// Bit that leaves the window WINDOW_DEPTH inputs later
function automatic void push_expected(input logic d);
    exp_q.push_back(d);
endfunction

// Fresh start, encoder at zero and window full of zeros
function automatic void clear_model();
    enc_sr = '0;
    exp_q.delete();
    for (int i = 0; i < WINDOW_DEPTH; i++) begin
        exp_q.push_back(1'b0);
    end
endfunction

`endif

//--- dv/tb_fano_decoder.sv
`timescale 1ns/1ps

module tb_fano_decoder;
    import fano_pkg::*;

    localparam int CLK_HALF = 5;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 35786;
    // One branch every INPUT_GAP cycles
    localparam int INPUT_GAP = 24;
    // One flipped bit per block in the sparse run
    localparam int ERR_BLOCK = 48;
    localparam int CLEAN_SYMS = 500;
    localparam int SPARSE_SYMS = 1000;
    localparam int LONG_SYMS = 2000;
    localparam int PRE_RESET_SYMS = 200;
    localparam int POST_RESET_SYMS = 300;
    localparam int TOTAL_SYMS = CLEAN_SYMS + SPARSE_SYMS + LONG_SYMS
                              + PRE_RESET_SYMS + POST_RESET_SYMS;
    localparam int TIMEOUT_CYCLES = TOTAL_SYMS * INPUT_GAP + 2000;
    // Halvings expected over the long run
    localparam int MIN_NORMS = 3;

    logic        clk;
    logic        nlocal_rst;
    logic        i_vld;
    branch_t     i_branch;
    logic        o_vld;
    logic        o_dec_sym;

    // Monitor state
    string       cur_test = "reset";
    logic        rst_prev = 1'b0;
    logic        vld_prev = 1'b0;
    logic        pre_input = 1'b1;
    logic        count_norms = 1'b0;
    int          norm_cnt = 0;
    int unsigned cycle_cnt = 0;

    `include "fano_tb_model.svh"

    fano_decoder_top i_fano_decoder_top (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_vld      (i_vld),
        .i_branch   (i_branch),
        .o_vld      (o_vld),
        .o_dec_sym  (o_dec_sym)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int exp, input int act);
        stop_with_failure($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Called on a rising edge
    task automatic apply_reset();
        nlocal_rst <= 1'b0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        nlocal_rst <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    // One strobe then idle up to the next slot
    task automatic drive_branch(input branch_t br);
        @(posedge clk);
        i_vld <= 1'b1;
        i_branch <= br;
        @(posedge clk);
        i_vld <= 1'b0;
        repeat (INPUT_GAP - 2) @(posedge clk);
    endtask

    task automatic run_stream(input string name, input int n, input logic with_errors);
        int      err_pos;
        logic    err_on_data;
        logic    d;
        branch_t br;
        cur_test = name;
        err_pos = 0;
        err_on_data = 1'b0;
        for (int i = 0; i < n; i++) begin
            // New error spot per block
            if (i % ERR_BLOCK == 0) begin
                err_pos = $urandom_range(ERR_BLOCK - 1);
                err_on_data = $urandom_range(1);
            end
            d = $urandom_range(1);
            br = encode_bit(d);
            push_expected(d);
            if (with_errors && (i % ERR_BLOCK == err_pos)) begin
                br = flip_one(br, err_on_data);
            end
            drive_branch(br);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        nlocal_rst = 1'b0;
        i_vld = 1'b0;
        i_branch = '0;
        @(posedge clk);
        apply_reset();
        run_stream("error_free", CLEAN_SYMS, 1'b0);
        run_stream("sparse_errors", SPARSE_SYMS, 1'b1);
        // Threshold wraps through halving several times here
        count_norms = 1'b1;
        run_stream("long_run", LONG_SYMS, 1'b0);
        count_norms = 1'b0;
        assert (norm_cnt >= MIN_NORMS) else begin
            stop_with_failure("Threshold did not reach the halving point often in long_run");
        end
        // Reset in the middle of a stream
        run_stream("mid_reset_pre", PRE_RESET_SYMS, 1'b0);
        cur_test = "reset";
        apply_reset();
        run_stream("mid_reset_post", POST_RESET_SYMS, 1'b0);
        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Output monitor sampling mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic exp_bit;
        if (!rst_prev) begin
            // DUT has seen reset on the last edge
            assert (!o_vld) else report_mismatch("reset o_vld", 0, o_vld);
            assert (!o_dec_sym) else report_mismatch("reset o_dec_sym", 0, o_dec_sym);
            pre_input = 1'b1;
        end else begin
            // Strobe one clock after the input
            assert (o_vld == vld_prev) else begin
                report_mismatch({cur_test, " o_vld"}, vld_prev, o_vld);
            end
            if (pre_input) begin
                assert (!o_dec_sym) else report_mismatch("reset o_dec_sym", 0, o_dec_sym);
            end
            if (o_vld) begin
                assert (exp_q.size() > 0) else begin
                    stop_with_failure("Output strobe with no bit left in the model queue");
                end
                exp_bit = exp_q.pop_front();
                assert (o_dec_sym == exp_bit) else begin
                    report_mismatch(cur_test, exp_bit, o_dec_sym);
                end
            end
            if (i_vld) begin
                pre_input = 1'b0;
            end
        end
        if (count_norms && i_fano_decoder_top.cmd.norm) begin
            norm_cnt++;
        end
        vld_prev = i_vld;
        rst_prev = nlocal_rst;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout after %0d cycles", cycle_cnt));
        end
    end

endmodule

//--- hw/fano_decoder_top.sv
`timescale 1ns/1ps

module fano_decoder_top (
    input  logic              clk,
    input  logic              nlocal_rst,
    input  logic              i_vld,
    input  fano_pkg::branch_t i_branch,
    output logic              o_vld,
    output logic              o_dec_sym
);
    import fano_pkg::*;

    ctrl_cmd_t              cmd;
    ptr_t                   ptr;
    logic [FWD_CNT_W-1:0]   fwd_cnt;
    metric_flags_t          flags;
    logic                   worst_here;
    // Forward job, branch at the pointer
    logic [CODE_LEN-1:0]    fwd_hist;
    branch_t                fwd_branch;
    logic                   fwd_worst;
    bm_result_t             fwd_res;
    // Backward job, one slot deeper
    logic [CODE_LEN-1:0]    back_hist;
    branch_t                back_branch;
    logic                   back_worst;
    bm_result_t             back_res;

    fano_ctrl u_ctrl (
        .clk          (clk),
        .nlocal_rst   (nlocal_rst),
        .i_vld        (i_vld),
        .i_flags      (flags),
        .i_worst_here (worst_here),
        .i_fwd_done   (fwd_res.vld),
        .i_back_done  (back_res.vld),
        .o_cmd        (cmd),
        .o_ptr        (ptr),
        .o_fwd_cnt    (fwd_cnt)
    );

    path_memory u_path_memory (
        .clk           (clk),
        .nlocal_rst    (nlocal_rst),
        .i_vld         (i_vld),
        .i_branch      (i_branch),
        .i_cmd         (cmd),
        .i_ptr         (ptr),
        .i_fwd_bit     (fwd_res.dec),
        .o_fwd_hist    (fwd_hist),
        .o_back_hist   (back_hist),
        .o_fwd_branch  (fwd_branch),
        .o_back_branch (back_branch),
        .o_fwd_worst   (fwd_worst),
        .o_back_worst  (back_worst),
        .o_worst_here  (worst_here),
        .o_vld         (o_vld),
        .o_dec_sym     (o_dec_sym)
    );

    branch_metric fwd_bm (
        .clk          (clk),
        .nlocal_rst   (nlocal_rst),
        .i_start      (cmd.start_fwd_calc),
        .i_hist       (fwd_hist),
        .i_rx         (fwd_branch),
        .i_take_worst (fwd_worst),
        .o_res        (fwd_res)
    );

    branch_metric back_bm (
        .clk          (clk),
        .nlocal_rst   (nlocal_rst),
        .i_start      (cmd.start_back_calc),
        .i_hist       (back_hist),
        .i_rx         (back_branch),
        .i_take_worst (back_worst),
        .o_res        (back_res)
    );

    path_metric_regs u_metric_regs (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_cmd      (cmd),
        .i_fwd_cnt  (fwd_cnt),
        .i_fwd_res  (fwd_res),
        .i_back_res (back_res),
        .o_flags    (flags)
    );

endmodule

//--- hw/path_metric_regs.sv
`timescale 1ns/1ps

module path_metric_regs (
    input  logic                            clk,
    input  logic                            nlocal_rst,
    input  fano_pkg::ctrl_cmd_t             i_cmd,
    input  logic [fano_pkg::FWD_CNT_W-1:0]  i_fwd_cnt,
    input  fano_pkg::bm_result_t            i_fwd_res,
    input  fano_pkg::bm_result_t            i_back_res,
    output fano_pkg::metric_flags_t         o_flags
);
    import fano_pkg::*;

    // Threshold, current, previous and candidate metrics
    logic signed [METRIC_W-1:0] t_q;
    logic signed [METRIC_W-1:0] mc_q;
    logic signed [METRIC_W-1:0] mp_q;
    logic signed [METRIC_W-1:0] ms_q;
    // Sign-extended branch metrics
    logic signed [METRIC_W-1:0] fwd_bm;
    logic signed [METRIC_W-1:0] back_bm;

    assign fwd_bm = {{(METRIC_W-BM_W){i_fwd_res.metric[BM_W-1]}}, i_fwd_res.metric};
    assign back_bm = {{(METRIC_W-BM_W){i_back_res.metric[BM_W-1]}}, i_back_res.metric};

    //////////////////////////////////////////////////////////////////////
    // Metric and threshold registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            t_q <= '0;
            mc_q <= '0;
            mp_q <= '0;
            ms_q <= '0;
        end else if (i_cmd.init) begin
            t_q <= '0;
            mc_q <= '0;
            ms_q <= '0;
            // Root has no parent
            mp_q <= METRIC_MIN;
        end else begin
            if (i_cmd.t_down) begin
                t_q <= t_q - DELTA_T;
            end else if (i_cmd.t_up) begin
                t_q <= t_q + DELTA_T;
            end else if (i_cmd.norm) begin
                t_q <= t_q >>> 1;
            end
            // Node metrics follow the moves
            if (i_cmd.fwd_move) begin
                mp_q <= mc_q;
                mc_q <= ms_q;
            end else if (i_cmd.back_move) begin
                mc_q <= mp_q;
            end else if (i_cmd.norm) begin
                mp_q <= mp_q >>> 1;
                mc_q <= mc_q >>> 1;
            end else if (i_back_res.vld) begin
                // New parent metric after stepping back
                if (i_fwd_cnt == '0) begin
                    mp_q <= METRIC_MIN;
                end else if (i_fwd_cnt == FWD_CNT_W'(1)) begin
                    mp_q <= '0;
                end else begin
                    mp_q <= mp_q - back_bm;
                end
            end
            // Candidate of the child under test
            if (i_fwd_res.vld) begin
                ms_q <= mc_q + fwd_bm;
            end else if (i_cmd.norm) begin
                ms_q <= ms_q >>> 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Comparison flags
    //////////////////////////////////////////////////////////////////////

    assign o_flags.ms_ge_t = ms_q >= t_q;
    assign o_flags.mp_ge_t = mp_q >= t_q;
    // Tightening check after a forward move
    assign o_flags.mp_below_next = mp_q < t_q + DELTA_T;
    assign o_flags.at_norm = t_q == NORM_STEP;

endmodule

//--- hw/branch_metric.sv
`timescale 1ns/1ps

module branch_metric (
    input  logic                          clk,
    input  logic                          nlocal_rst,
    input  logic                          i_start,
    input  logic [fano_pkg::CODE_LEN-1:0] i_hist,
    input  fano_pkg::branch_t             i_rx,
    input  logic                          i_take_worst,
    output fano_pkg::bm_result_t          o_res
);
    import fano_pkg::*;

    branch_t                hyp0;
    branch_t                hyp1;
    // Stage 1
    logic                   s1_vld;
    logic signed [BM_W-1:0] s1_m0;
    logic signed [BM_W-1:0] s1_m1;
    logic                   s1_worst;
    // Stage 2 choice
    logic                   pick;

    // Two-bit score of a hypothesis against the received branch
    function automatic logic signed [BM_W-1:0] score(branch_t hyp, branch_t rx);
        logic signed [BM_W-1:0] sd;
        logic signed [BM_W-1:0] sp;
        sd = (hyp.d == rx.d) ? METRIC_MATCH : METRIC_MISS;
        sp = (hyp.p == rx.p) ? METRIC_MATCH : METRIC_MISS;
        return sd + sp;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Re-encode both hypotheses
    //////////////////////////////////////////////////////////////////////

    // Newest bit at position 0 of the tap mask
    assign hyp0.d = 1'b0;
    assign hyp0.p = ^({i_hist[CODE_LEN-2:0], 1'b0} & PARITY_POLY);
    assign hyp1.d = 1'b1;
    assign hyp1.p = ^({i_hist[CODE_LEN-2:0], 1'b1} & PARITY_POLY);

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= i_start;
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            s1_m0 <= score(hyp0, i_rx);
            s1_m1 <= score(hyp1, i_rx);
            s1_worst <= i_take_worst;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Select
    //////////////////////////////////////////////////////////////////////

    // Tie keeps bit 0 as best
    assign pick = (s1_m1 > s1_m0) ^ s1_worst;

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            o_res.vld <= 1'b0;
        end else begin
            o_res.vld <= s1_vld;
        end
    end

    // Payload holds until the next job
    always_ff @(posedge clk) begin
        if (s1_vld) begin
            o_res.metric <= pick ? s1_m1 : s1_m0;
            o_res.dec <= pick;
        end
    end

endmodule

//--- hw/path_memory.sv
`timescale 1ns/1ps

module path_memory (
    input  logic                          clk,
    input  logic                          nlocal_rst,
    input  logic                          i_vld,
    input  fano_pkg::branch_t             i_branch,
    input  fano_pkg::ctrl_cmd_t           i_cmd,
    input  fano_pkg::ptr_t                i_ptr,
    input  logic                          i_fwd_bit,
    output logic [fano_pkg::CODE_LEN-1:0] o_fwd_hist,
    output logic [fano_pkg::CODE_LEN-1:0] o_back_hist,
    output fano_pkg::branch_t             o_fwd_branch,
    output fano_pkg::branch_t             o_back_branch,
    output logic                          o_fwd_worst,
    output logic                          o_back_worst,
    output logic                          o_worst_here,
    output logic                          o_vld,
    output logic                          o_dec_sym
);
    import fano_pkg::*;

    // Slot 0 holds the newest branch
    branch_t [WINDOW_DEPTH-1:0]       rx_win;
    logic [WINDOW_DEPTH-1:0]          dec_win;
    logic [WINDOW_DEPTH-1:0]          worst_win;
    logic [WINDOW_DEPTH-1:0]          dec_nxt;
    logic [WINDOW_DEPTH-1:0]          worst_nxt;
    // Zeros beyond the window match the encoder start state
    logic [WINDOW_DEPTH+CODE_LEN-1:0] dec_ext;
    ptr_t                             fwd_idx;
    ptr_t                             wr_idx;

    // Branch under test sits just above the pointer
    assign fwd_idx = i_ptr - 1'b1;
    // Same slot after this cycle's shift
    assign wr_idx = fwd_idx + ptr_t'(i_vld);

    //////////////////////////////////////////////////////////////////////
    // Selection at the pointer
    //////////////////////////////////////////////////////////////////////

    assign dec_ext = {{CODE_LEN{1'b0}}, dec_win};
    assign o_fwd_hist = dec_ext[i_ptr +: CODE_LEN];
    assign o_back_hist = dec_ext[i_ptr + 1 +: CODE_LEN];
    assign o_fwd_branch = rx_win[fwd_idx];
    assign o_back_branch = rx_win[i_ptr];
    assign o_back_worst = worst_win[i_ptr];
    assign o_worst_here = worst_win[fwd_idx];
    // Fresh start takes best, retry takes worst
    assign o_fwd_worst = i_cmd.mark_worst;

    //////////////////////////////////////////////////////////////////////
    // Window update
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec_nxt = i_vld ? {dec_win[WINDOW_DEPTH-2:0], 1'b0} : dec_win;
        worst_nxt = i_vld ? {worst_win[WINDOW_DEPTH-2:0], 1'b0} : worst_win;
        // Tentative decision of the forward move
        if (i_cmd.fwd_move) begin
            dec_nxt[wr_idx] = i_fwd_bit;
        end
        if (i_cmd.mark_worst) begin
            worst_nxt[wr_idx] = 1'b1;
        end else if (i_cmd.start_fwd_calc) begin
            worst_nxt[wr_idx] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!nlocal_rst || i_cmd.init) begin
            dec_win <= '0;
            worst_win <= '0;
        end else begin
            dec_win <= dec_nxt;
            worst_win <= worst_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            rx_win <= {rx_win[WINDOW_DEPTH-2:0], i_branch};
        end
    end

    // Oldest decision leaves as a new branch enters
    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            o_vld <= 1'b0;
            o_dec_sym <= 1'b0;
        end else begin
            o_vld <= i_vld;
            if (i_vld) begin
                o_dec_sym <= dec_win[WINDOW_DEPTH-1];
            end
        end
    end

endmodule

//--- hw/fano_ctrl.sv
`timescale 1ns/1ps

module fano_ctrl (
    input  logic                            clk,
    input  logic                            nlocal_rst,
    input  logic                            i_vld,
    input  fano_pkg::metric_flags_t         i_flags,
    input  logic                            i_worst_here,
    input  logic                            i_fwd_done,
    input  logic                            i_back_done,
    output fano_pkg::ctrl_cmd_t             o_cmd,
    output fano_pkg::ptr_t                  o_ptr,
    output logic [fano_pkg::FWD_CNT_W-1:0]  o_fwd_cnt
);
    import fano_pkg::*;

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        METRIC_CALC,
        FORWARD_MOVE,
        BACKWARD_MOVE
    } state_t;

    state_t         state_q;
    state_t         state_d;
    logic           norm_en_q;
    // Results are seen one cycle late, once the metric flags have settled
    logic           fwd_done_q;
    logic           back_done_q;
    // Backward job waits for the pointer to move first
    logic           start_back_q;
    logic [PTR_W:0] ptr_sum;

    //////////////////////////////////////////////////////////////////////
    // Search FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_cmd = '0;
        o_cmd.start_back_calc = start_back_q;
        state_d = state_q;
        case (state_q)
            INIT: begin
                o_cmd.init = 1'b1;
                state_d = IDLE;
            end
            IDLE: begin
                // Halve metrics and threshold before they overflow
                if (i_flags.at_norm && norm_en_q) begin
                    o_cmd.norm = 1'b1;
                end
                // Undecided branches waiting
                if (o_ptr != '0) begin
                    o_cmd.start_fwd_calc = 1'b1;
                    state_d = METRIC_CALC;
                end
            end
            METRIC_CALC: begin
                if (fwd_done_q) begin
                    if (i_flags.ms_ge_t) begin
                        o_cmd.fwd_move = 1'b1;
                        state_d = FORWARD_MOVE;
                    end else if (i_flags.mp_ge_t) begin
                        o_cmd.back_move = 1'b1;
                        state_d = BACKWARD_MOVE;
                    end else begin
                        // Both ways blocked
                        o_cmd.t_down = 1'b1;
                        state_d = IDLE;
                    end
                end
            end
            FORWARD_MOVE: begin
                // First visit of this node, tighten
                o_cmd.t_up = i_flags.mp_below_next;
                state_d = IDLE;
            end
            BACKWARD_MOVE: begin
                if (back_done_q) begin
                    if (i_worst_here) begin
                        // Both children tried here
                        if (i_flags.mp_ge_t) begin
                            o_cmd.back_move = 1'b1;
                        end else begin
                            o_cmd.t_down = 1'b1;
                            state_d = IDLE;
                        end
                    end else begin
                        // Retry along the worse branch
                        o_cmd.mark_worst = 1'b1;
                        o_cmd.start_fwd_calc = 1'b1;
                        state_d = METRIC_CALC;
                    end
                end
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            state_q <= INIT;
            norm_en_q <= 1'b0;
            fwd_done_q <= 1'b0;
            back_done_q <= 1'b0;
            start_back_q <= 1'b0;
        end else begin
            state_q <= state_d;
            fwd_done_q <= i_fwd_done;
            back_done_q <= i_back_done;
            start_back_q <= o_cmd.back_move;
            // Rearmed once per metric pass
            if (o_cmd.init || state_q == METRIC_CALC) begin
                norm_en_q <= 1'b1;
            end else if (o_cmd.norm) begin
                norm_en_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tree pointer and forward step counter
    //////////////////////////////////////////////////////////////////////

    // New input and backward move both go deeper
    assign ptr_sum = {1'b0, o_ptr} + (PTR_W+1)'(i_vld) + (PTR_W+1)'(o_cmd.back_move)
                     - (PTR_W+1)'(o_cmd.fwd_move);

    always_ff @(posedge clk) begin
        if (!nlocal_rst || o_cmd.init) begin
            o_ptr <= '0;
        end else if (ptr_sum > PTR_MAX) begin
            o_ptr <= ptr_t'(PTR_MAX);
        end else begin
            o_ptr <= ptr_sum[PTR_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!nlocal_rst || o_cmd.init) begin
            o_fwd_cnt <= '0;
        end else if (o_cmd.fwd_move && o_fwd_cnt != '1) begin
            o_fwd_cnt <= o_fwd_cnt + 1'b1;
        end else if (o_cmd.back_move && o_fwd_cnt != '0) begin
            o_fwd_cnt <= o_fwd_cnt - 1'b1;
        end
    end

endmodule

//--- hw/fano_pkg.sv
package fano_pkg;

    //////////////////////////////////////////////////////////////////////
    // Code and window geometry
    //////////////////////////////////////////////////////////////////////

    // Branches held in the search window
    localparam int WINDOW_DEPTH = 64;
    // Constraint length of the parity generator
    localparam int CODE_LEN = 12;
    // Parity taps, bit 0 is the newest information bit
    localparam logic [CODE_LEN-1:0] PARITY_POLY = 12'hB2D;

    // Pointer range, deepest slot keeps a full history inside the window
    localparam int PTR_W = $clog2(WINDOW_DEPTH);
    localparam int PTR_MAX = WINDOW_DEPTH - CODE_LEN;
    // Forward step counter width
    localparam int FWD_CNT_W = 12;

    //////////////////////////////////////////////////////////////////////
    // Metrics and threshold
    //////////////////////////////////////////////////////////////////////

    localparam int METRIC_W = 16;
    localparam int BM_W = 6;
    // Per-bit scores
    localparam logic signed [BM_W-1:0] METRIC_MATCH = 6'sd1;
    localparam logic signed [BM_W-1:0] METRIC_MISS = -6'sd5;
    // Threshold step and halving point
    localparam logic signed [METRIC_W-1:0] DELTA_T = 16'sd4;
    localparam logic signed [METRIC_W-1:0] NORM_STEP = 16'sd256;
    // Previous metric of the root node
    localparam logic signed [METRIC_W-1:0] METRIC_MIN = {1'b1, {(METRIC_W-1){1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////////////////////////

    typedef logic [PTR_W-1:0] ptr_t;

    // Information bit and parity bit
    typedef struct packed {
        logic d;
        logic p;
    } branch_t;

    typedef struct packed {
        logic                   vld;
        logic signed [BM_W-1:0] metric;
        logic                   dec;
    } bm_result_t;

    // One-cycle controller commands
    typedef struct packed {
        logic init;
        logic start_fwd_calc;
        logic start_back_calc;
        logic fwd_move;
        logic back_move;
        logic t_up;
        logic t_down;
        logic norm;
        logic mark_worst;
    } ctrl_cmd_t;

    typedef struct packed {
        logic ms_ge_t;
        logic mp_ge_t;
        logic mp_below_next;
        logic at_norm;
    } metric_flags_t;

endpackage
